//--- source/conv_router_pkg.sv
package conv_router_pkg;

    ////////////////////////////////////////////////////////////
    // basic scalar types
    ////////////////////////////////////////////////////////////

    // layer coordinate, count or address
    typedef logic [15:0] coord_t;
    // kernel size, stride or padding
    typedef logic [3:0] kernel_t;
    // ring buffer select, 0 to 2
    typedef logic [1:0] buf_idx_t;

    // marks a row or address that does not exist
    localparam coord_t NO_ROW = 16'hffff;

    // output rows per tile, also the number of ring buffers
    localparam int ROWS_PER_PASS = 3;

    ////////////////////////////////////////////////////////////
    // line buffer geometry
    ////////////////////////////////////////////////////////////

    // 32 channels, 32 pixels per line, 64 lines per buffer
    localparam int CHANNEL_BITS = 5;
    localparam int PIXEL_BITS   = 5;
    localparam int LINE_BITS    = 6;

    // buffer address, filled by field and read as one word
    typedef union packed {
        coord_t flat;
        struct packed {
            logic [LINE_BITS-1:0]    line;
            logic [PIXEL_BITS-1:0]   pixel;
            logic [CHANNEL_BITS-1:0] channel;
        } field;
    } buf_adr_u;

endpackage

//--- source/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer #(
    parameter int TILE_OX = 4,
    parameter int TILE_OY = 3,
    parameter int TILE_OF = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    en,
    input  conv_router_pkg::coord_t ox,
    input  conv_router_pkg::coord_t oy,
    input  conv_router_pkg::coord_t of,
    input  conv_router_pkg::coord_t nif,
    input  logic                    pass_done,
    output conv_router_pkg::coord_t ox_start,
    output conv_router_pkg::coord_t oy_start,
    output conv_router_pkg::coord_t of_start,
    output conv_router_pkg::coord_t pox,
    output conv_router_pkg::coord_t poy,
    output conv_router_pkg::coord_t pof,
    output conv_router_pkg::coord_t if_idx,
    output logic                    scanning,
    output logic                    loop_if_end,
    output logic                    conv_end
);
    import conv_router_pkg::*;

    // nominal tile sizes as coordinates
    localparam coord_t TOX = coord_t'(TILE_OX);
    localparam coord_t TOY = coord_t'(TILE_OY);
    localparam coord_t TOF = coord_t'(TILE_OF);

    // remaining extent from the tile start, 1-based
    coord_t rem_ox;
    coord_t rem_oy;
    coord_t rem_of;
    logic   last_if;
    logic   last_of;
    logic   last_ox;
    logic   last_oy;

    ////////////////////////////////////////////////////////////
    // edge clipping
    ////////////////////////////////////////////////////////////

    assign rem_ox = ox - ox_start + 16'd1;
    assign rem_oy = oy - oy_start + 16'd1;
    assign rem_of = of - of_start + 16'd1;

    // clipped size never exceeds the tile
    assign pox = (rem_ox < TOX) ? rem_ox : TOX;
    assign poy = (rem_oy < TOY) ? rem_oy : TOY;
    assign pof = (rem_of < TOF) ? rem_of : TOF;

    // last channel / last tile along each axis
    assign last_if = (if_idx == nif);
    assign last_of = (of_start + TOF > of);
    assign last_ox = (ox_start + TOX > ox);
    assign last_oy = (oy_start + TOY > oy);

    // tile finished after its last channel pass
    assign loop_if_end = pass_done && last_if;
    // whole layer finished
    assign conv_end = loop_if_end && last_of && last_ox && last_oy;

    ////////////////////////////////////////////////////////////
    // nested counters, of fastest then ox then oy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ox_start <= '0;
            oy_start <= '0;
            of_start <= '0;
            if_idx   <= '0;
            scanning <= 1'b0;
        end else if (en) begin
            // first tile, first channel
            ox_start <= 16'd1;
            oy_start <= 16'd1;
            of_start <= 16'd1;
            if_idx   <= 16'd1;
            scanning <= 1'b1;
        end else if (pass_done) begin
            if (!last_if) begin
                if_idx <= if_idx + 16'd1;
            end else begin
                if_idx <= 16'd1;
                if (!last_of) begin
                    of_start <= of_start + TOF;
                end else begin
                    of_start <= 16'd1;
                    if (!last_ox) begin
                        ox_start <= ox_start + TOX;
                    end else begin
                        ox_start <= 16'd1;
                        if (!last_oy) begin
                            oy_start <= oy_start + TOY;
                        end else begin
                            // final pass of the layer
                            oy_start <= 16'd1;
                            scanning <= 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- source/window_scanner.sv
`timescale 1ns/1ps

module window_scanner (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     scanning,
    input  logic                     ifx_stall,
    input  conv_router_pkg::coord_t  ox_start,
    input  conv_router_pkg::coord_t  pox,
    input  conv_router_pkg::kernel_t k,
    input  conv_router_pkg::kernel_t s,
    input  conv_router_pkg::kernel_t p,
    output logic                     step_valid,
    output conv_router_pkg::kernel_t idx_in_k,
    output conv_router_pkg::coord_t  in_col,
    output logic                     pass_done
);
    import conv_router_pkg::*;

    // column and kernel row position inside the pass
    coord_t  col_cnt;
    kernel_t row_cnt;

    // pass geometry
    coord_t pox_span;
    coord_t n_cols;
    coord_t ox_base;
    coord_t col_base;
    logic   last_col;
    logic   last_row;

    ////////////////////////////////////////////////////////////
    // pass geometry from the tile and the kernel
    ////////////////////////////////////////////////////////////

    // (pox - 1) * s, stride 1 or 2 only
    assign pox_span = (s == 4'd2) ? ((pox - 16'd1) << 1) : (pox - 16'd1);
    // input columns needed by the tile
    assign n_cols = pox_span + coord_t'(k);

    // (ox_start - 1) * s
    assign ox_base = (s == 4'd2) ? ((ox_start - 16'd1) << 1) : (ox_start - 16'd1);
    // leftmost input column, 0 when it lies in the pad
    assign col_base = ox_base + 16'd1 - coord_t'(p);

    // one column per step while not held
    assign step_valid = scanning && !ifx_stall;

    assign last_col  = (col_cnt == n_cols - 16'd1);
    assign last_row  = (row_cnt == k - 4'd1);
    assign pass_done = step_valid && last_col && last_row;

    assign idx_in_k = row_cnt;
    assign in_col   = col_base + col_cnt;

    ////////////////////////////////////////////////////////////
    // column inner, kernel row outer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (step_valid) begin
            if (!last_col) begin
                col_cnt <= col_cnt + 16'd1;
            end else begin
                col_cnt <= '0;
                // wraps to row 0 at the end of a pass
                if (last_row) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 4'd1;
                end
            end
        end
    end

endmodule

//--- source/row_addresser.sv
`timescale 1ns/1ps

module row_addresser #(
    parameter int ROW_SLOT = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step_valid,
    input  conv_router_pkg::coord_t   oy_start,
    input  conv_router_pkg::coord_t   poy,
    input  conv_router_pkg::coord_t   iy,
    input  conv_router_pkg::coord_t   ix,
    input  conv_router_pkg::kernel_t  s,
    input  conv_router_pkg::kernel_t  p,
    input  conv_router_pkg::kernel_t  idx_in_k,
    input  conv_router_pkg::coord_t   in_col,
    input  conv_router_pkg::coord_t   if_idx,
    output conv_router_pkg::coord_t   row_idx,
    output conv_router_pkg::buf_idx_t buf_idx,
    output conv_router_pkg::coord_t   buf_adr,
    output logic                      valid_adr
);
    import conv_router_pkg::*;

    coord_t      base0;
    coord_t      slot_off;
    coord_t      row_in;
    logic [32:0] q_prod;
    coord_t      q;
    coord_t      q_adj;
    logic [1:0]  m;
    coord_t      bias_raw;
    coord_t      bias;
    logic [1:0]  off;
    buf_idx_t    fold_idx;
    logic        slot_ok;
    buf_adr_u    adr_word;

    // tile base row (oy_start - 1) * s and this slot's offset r * s
    assign base0    = (s == 4'd2) ? ((oy_start - 16'd1) << 1) : (oy_start - 16'd1);
    assign slot_off = coord_t'(ROW_SLOT) * coord_t'(s);
    // 1-based input row, 0 lies in the top pad
    assign row_in = base0 + slot_off + coord_t'(idx_in_k) + 16'd1 - coord_t'(p);

    // split base into 3q + m, reciprocal of 3 is exact over 16 bits
    assign q_prod = {17'd0, base0} * 33'd43691;
    assign q      = q_prod[32:17];
    assign m      = 2'(base0 - (q << 1) - q);

    // small bias, row_in = 3q + bias_raw
    assign bias_raw = coord_t'(m) + slot_off + coord_t'(idx_in_k) + 16'd1 - coord_t'(p);
    // zero bias borrows one line from the base
    assign bias  = (bias_raw == '0) ? 16'd3 : bias_raw;
    assign q_adj = (bias_raw == '0) ? (q - 16'd1) : q;

    // mod and div by 3 of the bias by range
    always_comb begin
        if (bias <= 16'd3) begin
            off      = 2'd0;
            fold_idx = 2'(bias - 16'd1);
        end else if (bias <= 16'd6) begin
            off      = 2'd1;
            fold_idx = 2'(bias - 16'd4);
        end else if (bias <= 16'd9) begin
            off      = 2'd2;
            fold_idx = 2'(bias - 16'd7);
        end else begin
            off      = 2'd3;
            fold_idx = 2'(bias - 16'd10);
        end
    end

    // slot inside the tile, row and column inside the layer
    assign slot_ok = step_valid && (coord_t'(ROW_SLOT) < poy)
                     && (row_in >= 16'd1) && (row_in <= iy)
                     && (in_col >= 16'd1) && (in_col <= ix);

    always_comb begin
        adr_word.field.line    = LINE_BITS'(q_adj + coord_t'(off));
        adr_word.field.pixel   = PIXEL_BITS'(in_col - 16'd1);
        adr_word.field.channel = CHANNEL_BITS'(if_idx - 16'd1);
    end

    // one register stage behind the step
    always_ff @(posedge clk) begin
        if (reset) begin
            row_idx   <= NO_ROW;
            buf_idx   <= '0;
            buf_adr   <= NO_ROW;
            valid_adr <= 1'b0;
        end else begin
            row_idx   <= slot_ok ? row_in : NO_ROW;
            buf_idx   <= slot_ok ? fold_idx : buf_idx_t'(0);
            buf_adr   <= slot_ok ? adr_word.flat : NO_ROW;
            valid_adr <= slot_ok;
        end
    end

endmodule

//--- source/tile_handover.sv
`timescale 1ns/1ps

module tile_handover (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     loop_if_end,
    input  logic                     channel_out_done,
    input  logic                     conv_out_done,
    input  conv_router_pkg::coord_t  nif,
    input  conv_router_pkg::kernel_t k,
    input  conv_router_pkg::coord_t  ox_start,
    input  conv_router_pkg::coord_t  oy_start,
    input  conv_router_pkg::coord_t  of_start,
    input  conv_router_pkg::coord_t  pox,
    input  conv_router_pkg::coord_t  poy,
    input  conv_router_pkg::coord_t  pof,
    output logic                     ifx_stall,
    output conv_router_pkg::coord_t  cur_ox_start,
    output conv_router_pkg::coord_t  cur_oy_start,
    output conv_router_pkg::coord_t  cur_of_start,
    output conv_router_pkg::coord_t  cur_pox,
    output conv_router_pkg::coord_t  cur_poy,
    output conv_router_pkg::coord_t  cur_pof
);
    import conv_router_pkg::*;

    // compute work per tile vs drain work of the finished tile
    coord_t nif_k_k;
    coord_t pof_poy;
    logic   release_stall;
    logic   load_tile;

    assign nif_k_k = nif * coord_t'(k) * coord_t'(k);

    // poy is 1 to 3, shift and add
    always_comb begin
        case (cur_poy)
            16'd1:   pof_poy = cur_pof;
            16'd2:   pof_poy = cur_pof << 1;
            16'd3:   pof_poy = (cur_pof << 1) + cur_pof;
            default: pof_poy = '0;
        endcase
    end

    // compute-bound tiles wait on the channel drain,
    // drain-bound tiles wait on the full output drain
    assign release_stall = ifx_stall
                           && ((channel_out_done && (nif_k_k > pof_poy))
                           || (conv_out_done && (nif_k_k <= pof_poy)));

    // follow the sequencer until stalled, take the new tile on release
    assign load_tile = !ifx_stall || release_stall;

    ////////////////////////////////////////////////////////////
    // stall flag and current tile
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ifx_stall <= 1'b0;
        end else if (loop_if_end) begin
            ifx_stall <= 1'b1;
        end else if (release_stall) begin
            ifx_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_ox_start <= '0;
            cur_oy_start <= '0;
            cur_of_start <= '0;
            cur_pox      <= '0;
            cur_poy      <= '0;
            cur_pof      <= '0;
        end else if (load_tile) begin
            cur_ox_start <= ox_start;
            cur_oy_start <= oy_start;
            cur_of_start <= of_start;
            cur_pox      <= pox;
            cur_poy      <= poy;
            cur_pof      <= pof;
        end
    end

endmodule

//--- source/conv_router.sv
`timescale 1ns/1ps

module conv_router #(
    parameter int TILE_OX = 4,
    parameter int TILE_OY = 3,
    parameter int TILE_OF = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  conv_router_pkg::coord_t   ox,
    input  conv_router_pkg::coord_t   oy,
    input  conv_router_pkg::coord_t   of,
    input  conv_router_pkg::coord_t   ix,
    input  conv_router_pkg::coord_t   iy,
    input  conv_router_pkg::coord_t   nif,
    input  conv_router_pkg::kernel_t  k,
    input  conv_router_pkg::kernel_t  s,
    input  conv_router_pkg::kernel_t  p,
    input  logic                      channel_out_done,
    input  logic                      conv_out_done,
    output logic                      conv_end,
    output logic                      ifx_stall,
    output conv_router_pkg::coord_t   cur_ox_start,
    output conv_router_pkg::coord_t   cur_oy_start,
    output conv_router_pkg::coord_t   cur_of_start,
    output conv_router_pkg::coord_t   cur_pox,
    output conv_router_pkg::coord_t   cur_poy,
    output conv_router_pkg::coord_t   cur_pof,
    output conv_router_pkg::coord_t   row_idx       [conv_router_pkg::ROWS_PER_PASS],
    output conv_router_pkg::buf_idx_t row_buf_idx   [conv_router_pkg::ROWS_PER_PASS],
    output conv_router_pkg::coord_t   row_buf_adr   [conv_router_pkg::ROWS_PER_PASS],
    output logic                      valid_row_adr [conv_router_pkg::ROWS_PER_PASS],
    output logic                      adr_valid,
    output conv_router_pkg::coord_t   if_idx_out
);
    import conv_router_pkg::*;

    // sequencer tile, valid while scanning
    coord_t  ox_start;
    coord_t  oy_start;
    coord_t  of_start;
    coord_t  pox;
    coord_t  poy;
    coord_t  pof;
    coord_t  if_idx;
    logic    scanning;
    logic    loop_if_end;

    // scanner step
    logic    step_valid;
    kernel_t idx_in_k;
    coord_t  in_col;
    logic    pass_done;

    assign if_idx_out = if_idx;

    tile_sequencer #(
        .TILE_OX (TILE_OX),
        .TILE_OY (TILE_OY),
        .TILE_OF (TILE_OF)
    ) u_sequencer (
        .clk, .reset, .en, .ox, .oy, .of, .nif, .pass_done,
        .ox_start, .oy_start, .of_start, .pox, .poy, .pof, .if_idx,
        .scanning, .loop_if_end, .conv_end
    );

    window_scanner u_scanner (
        .clk, .reset, .scanning, .ifx_stall, .ox_start, .pox, .k, .s, .p,
        .step_valid, .idx_in_k, .in_col, .pass_done
    );

    ////////////////////////////////////////////////////////////
    // one addresser per output row of the tile
    ////////////////////////////////////////////////////////////

    for (genvar r = 0; r < ROWS_PER_PASS; r++) begin : g_row
        row_addresser #(
            .ROW_SLOT (r)
        ) u_addresser (
            .clk, .reset, .step_valid, .oy_start, .poy, .iy, .ix, .s, .p,
            .idx_in_k, .in_col, .if_idx,
            .row_idx   (row_idx[r]),
            .buf_idx   (row_buf_idx[r]),
            .buf_adr   (row_buf_adr[r]),
            .valid_adr (valid_row_adr[r])
        );
    end

    tile_handover u_handover (
        .clk, .reset, .loop_if_end, .channel_out_done, .conv_out_done, .nif, .k,
        .ox_start, .oy_start, .of_start, .pox, .poy, .pof,
        .ifx_stall, .cur_ox_start, .cur_oy_start, .cur_of_start,
        .cur_pox, .cur_poy, .cur_pof
    );

    // step strobe aligned with the addresser register
    always_ff @(posedge clk) begin
        if (reset) begin
            adr_valid <= 1'b0;
        end else begin
            adr_valid <= step_valid;
        end
    end

endmodule

//--- verification/conv_router_assert.sv
`timescale 1ns/1ps

module conv_router_assert (
    input logic                      clk,
    input logic                      reset,
    input logic                      conv_end,
    input logic                      ifx_stall,
    input logic                      adr_valid,
    input conv_router_pkg::buf_idx_t row_buf_idx   [conv_router_pkg::ROWS_PER_PASS],
    input logic                      valid_row_adr [conv_router_pkg::ROWS_PER_PASS]
);
    import conv_router_pkg::*;

    // empty slot points at buffer 0
    for (genvar r = 0; r < ROWS_PER_PASS; r++) begin : g_slot
        a_idle_slot: assert property (@(posedge clk) disable iff (reset)
            !valid_row_adr[r] |-> row_buf_idx[r] == buf_idx_t'(0))
            else $error("slot %0d invalid with a nonzero buffer index", r);
    end

    // last step of a tile may still leave the pipe on the first stall cycle only
    a_stall_quiet: assert property (@(posedge clk) disable iff (reset)
        ifx_stall && $past(ifx_stall) |-> !adr_valid)
        else $error("address step two cycles into a stall");

    // end of layer is a single strobe
    a_end_pulse: assert property (@(posedge clk) disable iff (reset)
        conv_end |=> !conv_end)
        else $error("conv_end held for more than one cycle");

endmodule

bind conv_router conv_router_assert u_assert (
    .clk, .reset, .conv_end, .ifx_stall, .adr_valid, .row_buf_idx, .valid_row_adr
);

//--- verification/conv_router_tb.sv
`timescale 1ns/1ps

module conv_router_tb;
    import conv_router_pkg::*;

    localparam int TILE_OX     = 4;
    localparam int TILE_OY     = 3;
    localparam int TILE_OF     = 2;
    localparam int N_CFG       = 5;
    localparam int CYCLE_LIMIT = 5000;

    // one expected address step, tile plus three row slots
    typedef struct packed {
        coord_t         ox_s;
        coord_t         oy_s;
        coord_t         of_s;
        coord_t         pox;
        coord_t         poy;
        coord_t         pof;
        // input channel of the pass, 1-based
        coord_t         chan;
        coord_t   [2:0] row;
        buf_idx_t [2:0] bidx;
        coord_t   [2:0] adr;
        logic     [2:0] vld;
    } step_t;

    // layer table
    // columns ox, oy, of, ix, iy, nif, k, s, p
    int cfg [N_CFG][9] = '{
        '{5, 4, 3, 5, 4, 2, 3, 1, 1},
        '{7, 5, 2, 15, 11, 2, 3, 2, 0},
        '{6, 3, 4, 6, 3, 3, 1, 1, 0},
        '{4, 3, 1, 6, 4, 1, 2, 2, 1},
        '{3, 7, 2, 5, 9, 4, 3, 1, 0}
    };

    logic     clk = 1'b0;
    logic     reset;
    logic     en;
    coord_t   ox;
    coord_t   oy;
    coord_t   of;
    coord_t   ix;
    coord_t   iy;
    coord_t   nif;
    kernel_t  k;
    kernel_t  s;
    kernel_t  p;
    logic     channel_out_done;
    logic     conv_out_done;
    logic     conv_end;
    logic     ifx_stall;
    coord_t   cur_ox_start;
    coord_t   cur_oy_start;
    coord_t   cur_of_start;
    coord_t   cur_pox;
    coord_t   cur_poy;
    coord_t   cur_pof;
    coord_t   row_idx       [ROWS_PER_PASS];
    buf_idx_t row_buf_idx   [ROWS_PER_PASS];
    coord_t   row_buf_adr   [ROWS_PER_PASS];
    logic     valid_row_adr [ROWS_PER_PASS];
    logic     adr_valid;
    coord_t   if_idx_out;

    step_t exp_q [$];

    always #20 clk = ~clk;

    conv_router #(
        .TILE_OX (TILE_OX),
        .TILE_OY (TILE_OY),
        .TILE_OF (TILE_OF)
    ) uut (
        .clk, .reset, .en, .ox, .oy, .of, .ix, .iy, .nif, .k, .s, .p,
        .channel_out_done, .conv_out_done, .conv_end, .ifx_stall,
        .cur_ox_start, .cur_oy_start, .cur_of_start, .cur_pox, .cur_poy, .cur_pof,
        .row_idx, .row_buf_idx, .row_buf_adr, .valid_row_adr, .adr_valid, .if_idx_out
    );

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_coord(input string what, input coord_t got, input coord_t want);
        if (got !== want) begin
            fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, want));
        end
    endtask

    task automatic check_buf_idx(input string what, input buf_idx_t got, input buf_idx_t want);
        if (got !== want) begin
            fail_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, want));
        end
    endtask

    // current tile registers against a tile
    task automatic check_tile(input step_t item);
        check_coord("cur_ox_start", cur_ox_start, item.ox_s);
        check_coord("cur_oy_start", cur_oy_start, item.oy_s);
        check_coord("cur_of_start", cur_of_start, item.of_s);
        check_coord("cur_pox", cur_pox, item.pox);
        check_coord("cur_poy", cur_poy, item.poy);
        check_coord("cur_pof", cur_pof, item.pof);
    endtask

    task automatic check_step(input step_t item);
        int r;
        check_tile(item);
        for (r = 0; r < ROWS_PER_PASS; r++) begin
            check_coord($sformatf("row_idx[%0d]", r), row_idx[r], item.row[r]);
            check_buf_idx($sformatf("row_buf_idx[%0d]", r), row_buf_idx[r], item.bidx[r]);
            check_coord($sformatf("row_buf_adr[%0d]", r), row_buf_adr[r], item.adr[r]);
            check_flag($sformatf("valid_row_adr[%0d]", r), valid_row_adr[r], item.vld[r]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // line high, pixel middle, channel low
    function automatic coord_t pack_adr(input int row, input int col, input int chan);
        int word;
        word = (((row - 1) / 3) & ((1 << LINE_BITS) - 1)) << (PIXEL_BITS + CHANNEL_BITS);
        word = word | (((col - 1) & ((1 << PIXEL_BITS) - 1)) << CHANNEL_BITS);
        word = word | ((chan - 1) & ((1 << CHANNEL_BITS) - 1));
        return coord_t'(word);
    endfunction

    task automatic build_expected();
        int    oys;
        int    oxs;
        int    ofs;
        int    f;
        int    kr;
        int    c;
        int    r;
        int    tpx;
        int    tpy;
        int    tpf;
        int    ncol;
        int    col;
        int    row;
        step_t item;
        exp_q.delete();
        // rows of tiles outermost, features fastest
        for (oys = 1; oys <= int'(oy); oys += TILE_OY) begin
            for (oxs = 1; oxs <= int'(ox); oxs += TILE_OX) begin
                for (ofs = 1; ofs <= int'(of); ofs += TILE_OF) begin
                    // clip at the layer edge
                    tpx = (int'(ox) - oxs + 1 < TILE_OX) ? int'(ox) - oxs + 1 : TILE_OX;
                    tpy = (int'(oy) - oys + 1 < TILE_OY) ? int'(oy) - oys + 1 : TILE_OY;
                    tpf = (int'(of) - ofs + 1 < TILE_OF) ? int'(of) - ofs + 1 : TILE_OF;
                    item.ox_s = coord_t'(oxs);
                    item.oy_s = coord_t'(oys);
                    item.of_s = coord_t'(ofs);
                    item.pox  = coord_t'(tpx);
                    item.poy  = coord_t'(tpy);
                    item.pof  = coord_t'(tpf);
                    ncol = (tpx - 1) * int'(s) + int'(k);
                    for (f = 1; f <= int'(nif); f++) begin
                        item.chan = coord_t'(f);
                        for (kr = 0; kr < int'(k); kr++) begin
                            for (c = 0; c < ncol; c++) begin
                                col = (oxs - 1) * int'(s) + 1 - int'(p) + c;
                                for (r = 0; r < ROWS_PER_PASS; r++) begin
                                    row = (oys - 1) * int'(s) + 1 + r * int'(s) + kr - int'(p);
                                    if (r < tpy && row >= 1 && row <= int'(iy)
                                        && col >= 1 && col <= int'(ix)) begin
                                        item.row[r]  = coord_t'(row);
                                        item.bidx[r] = buf_idx_t'((row - 1) % 3);
                                        item.adr[r]  = pack_adr(row, col, f);
                                        item.vld[r]  = 1'b1;
                                    end else begin
                                        // pad row, pad column or slot past poy
                                        item.row[r]  = NO_ROW;
                                        item.bidx[r] = buf_idx_t'(0);
                                        item.adr[r]  = NO_ROW;
                                        item.vld[r]  = 1'b0;
                                    end
                                end
                                exp_q.push_back(item);
                            end
                        end
                    end
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one layer run
    ////////////////////////////////////////////////////////////

    task automatic run_layer(input int ci);
        int    cycles;
        int    n_end;
        int    n_steps;
        int    wait_left;
        int    release_wait;
        logic  stall_seen;
        logic  pulse_sent;
        logic  decoy;
        logic  use_channel;
        step_t last;
        step_t stall_tile;
        @(posedge clk);
        #2;
        ox  = coord_t'(cfg[ci][0]);
        oy  = coord_t'(cfg[ci][1]);
        of  = coord_t'(cfg[ci][2]);
        ix  = coord_t'(cfg[ci][3]);
        iy  = coord_t'(cfg[ci][4]);
        nif = coord_t'(cfg[ci][5]);
        k   = kernel_t'(cfg[ci][6]);
        s   = kernel_t'(cfg[ci][7]);
        p   = kernel_t'(cfg[ci][8]);
        build_expected();
        n_steps = exp_q.size();
        @(posedge clk);
        #2 en = 1'b1;
        @(posedge clk);
        #2 en = 1'b0;
        cycles       = 0;
        n_end        = 0;
        wait_left    = 0;
        release_wait = 0;
        stall_seen   = 1'b0;
        pulse_sent   = 1'b0;
        decoy        = 1'b0;
        use_channel  = 1'b0;
        while (!(n_end == 1 && exp_q.size() == 0 && !stall_seen)) begin
            // sample mid cycle
            @(negedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                fail_run($sformatf("timeout: layer %0d did not finish", ci));
            end
            if (adr_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("address step seen after the last expected one");
                end
                last = exp_q.pop_front();
                check_step(last);
            end
            // sequencer channel belongs to the step now in the scanner
            if (exp_q.size() != 0) begin
                check_coord("if_idx_out", if_idx_out, exp_q[0].chan);
            end
            if (conv_end) begin
                n_end++;
                if (n_end > 1) begin
                    fail_run("conv_end pulsed more than once in one layer");
                end
                // last step is still in the addresser stage
                if (exp_q.size() != 1) begin
                    fail_run($sformatf("Error at %0t ns: conv_end after %0d of %0d steps",
                                       $time, n_steps - exp_q.size() + 1, n_steps));
                end
            end
            if (ifx_stall && !stall_seen) begin
                stall_seen   = 1'b1;
                pulse_sent   = 1'b0;
                release_wait = 1;
                stall_tile   = last;
                wait_left    = int'($urandom_range(2, 6));
                decoy        = 1'($urandom_range(0, 1));
                // compute-bound tile waits on the channel drain
                use_channel = (int'(nif) * int'(k) * int'(k))
                              > (int'(last.pof) * int'(last.poy));
            end else if (stall_seen && !ifx_stall) begin
                if (!pulse_sent) begin
                    fail_run("stall released before the selecting done pulse");
                end
                stall_seen = 1'b0;
            end else if (stall_seen && pulse_sent) begin
                if (release_wait == 0) begin
                    fail_run("stall still held after the selecting done pulse");
                end
                release_wait--;
            end
            // finished tile stays in the cur registers while stalled
            if (stall_seen) begin
                check_tile(stall_tile);
            end
            @(posedge clk);
            #2;
            channel_out_done = 1'b0;
            conv_out_done    = 1'b0;
            if (stall_seen && !pulse_sent) begin
                wait_left--;
                if (wait_left == 0) begin
                    channel_out_done = use_channel;
                    conv_out_done    = !use_channel;
                    pulse_sent       = 1'b1;
                end else if (decoy && wait_left == 1) begin
                    // non-selecting done, must be ignored
                    channel_out_done = !use_channel;
                    conv_out_done    = use_channel;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int ci;
        void'($urandom(32'h9e5921ac));
        reset            = 1'b1;
        en               = 1'b0;
        ox               = '0;
        oy               = '0;
        of               = '0;
        ix               = '0;
        iy               = '0;
        nif              = '0;
        k                = '0;
        s                = '0;
        p                = '0;
        channel_out_done = 1'b0;
        conv_out_done    = 1'b0;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        for (ci = 0; ci < N_CFG; ci++) begin
            run_layer(ci);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- list.f
source/conv_router_pkg.sv
source/tile_sequencer.sv
source/window_scanner.sv
source/row_addresser.sv
source/tile_handover.sv
source/conv_router.sv
verification/conv_router_assert.sv
verification/conv_router_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
    --top-module conv_router_tb \
    -f list.f \
    -o conv_router_sim

sim_out=$(./obj_dir/conv_router_sim || true)
echo "$sim_out"
echo "$sim_out" | grep -qx "Everything OK"
